//--- Bender.yml
package:
  name: front_end

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/frontEndPkg.sv
      - verilog/fetchStage.sv
      - verilog/branchPredictor.sv
      - verilog/branchResolver.sv
      - verilog/frontEndTop.sv
  - target: simulation
    files:
      - verification/frontEnd_assertions.sv
      - verification/frontEnd_tb.sv

//--- sim.f
+incdir+verilog
verilog/frontEndPkg.sv
verilog/fetchStage.sv
verilog/branchPredictor.sv
verilog/branchResolver.sv
verilog/frontEndTop.sv
verification/frontEnd_assertions.sv
verification/frontEnd_tb.sv

//--- verification/frontEnd_assertions.sv
////////////////////////////////////////////////////////////
// Redirect, flush and BTB write checks on the resolver
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module frontEndAssertions (
    input logic                    clk,
    input logic                    reset,
    input logic                    redirectValid,
    input frontEndPkg::branchKindT execKind,
    input frontEndPkg::wordT       execInstr,
    input frontEndPkg::operandsT   operands,
    input logic                    btbWrite
);

    logic branchTaken;

    // funct3 bit 0 turns beq into bne
    assign branchTaken = (execKind == frontEndPkg::condBranch) &&
                         ((operands.rs1Value == operands.rs2Value) != execInstr[12]);

    // Both execute cycles of the penalty hold bubbles
    bubbleAfterRedirect: assert property (@(posedge clk) disable iff (reset)
        redirectValid |=> (execKind == frontEndPkg::none) [*2])
        else $error("Execute is not a bubble after a redirect");

    noBackToBackRedirect: assert property (@(posedge clk) disable iff (reset)
        redirectValid |=> (!redirectValid) [*2])
        else $error("Redirect again within the misprediction penalty");

    btbWriteOnTaken: assert property (@(posedge clk) disable iff (reset)
        btbWrite |-> (execKind == frontEndPkg::jump || branchTaken))
        else $error("BTB written for a branch that was not taken");

endmodule

bind branchResolver frontEndAssertions assertChk (
    .clk          (clk),
    .reset        (reset),
    .redirectValid(redirectValid_o),
    .execKind     (kindE),
    .execInstr    (instrE),
    .operands     (operandsE_i),
    .btbWrite     (update_o.btbWrite)
);

//--- verification/frontEnd_input.txt
# P addr instr rs1 rs2 (hex) | O cycle addr rs1 rs2 | S cycle | R cycle
# E firstCycle then pairs of expected pcF_o (hex) and mispredict_o
P 00 00000013 0 0
P 04 00000013 0 0
P 08 0100006F 0 0
P 0C 00000013 0 0
P 10 00000013 0 0
P 14 00000013 0 0
P 18 00208463 5 5
P 1C 00000013 0 0
P 20 00000013 0 0
P 24 FE209EE3 3 7
P 28 00000013 0 0
P 2C FD5FF06F 0 0
# bne at 0x24 falls through from cycle 27 on
O 27 24 5 5
S 41
S 42
S 43
R 48
E 0 00 0 04 0 08 0 0C 0 10 1 18 0
E 6 1C 0 20 1 20 0 24 0 28 0 2C 1
E 12 20 0 24 0 20 0 24 0 28 0 2C 1
E 18 20 0 24 0 20 0 24 0 20 0 24 0
E 24 28 0 2C 1 20 0 24 0 20 0 24 1
E 30 28 0 2C 0 30 0 34 1 00 0 04 0
E 36 08 0 18 0 20 0 24 0 20 0 24 1
E 42 28 0 28 0 28 0 2C 0 00 0 04 0
E 48 08 0 00 0 04 0 08 0 0C 0 10 1
E 54 18 0 1C 0 20 1 20 0

//--- verification/frontEnd_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the front end that serves the program,
// drives operands for execute and checks the fetch trace
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module frontEndTb;

    localparam int MemWords    = 64;
    localparam int MaxCycles   = 256;
    localparam int ResetCycles = 3;
    localparam frontEndPkg::wordT NopWord = 32'h0000_0013;

    logic                  clk;
    logic                  reset;
    logic                  stallF;
    frontEndPkg::wordT     instrF;
    frontEndPkg::operandsT operandsE;
    frontEndPkg::addrT     pcF;
    logic                  mispredict;

    // Program image and per cycle controls from the data file
    frontEndPkg::wordT     progWord [MemWords];
    frontEndPkg::operandsT progOps [MemWords];
    logic [MaxCycles-1:0]  stallAt;
    logic [MaxCycles-1:0]  resetAt;
    frontEndPkg::addrT     expPc [MaxCycles];
    logic                  expMis [MaxCycles];
    int                    chgCycle [$];
    frontEndPkg::addrT     chgAddr [$];
    frontEndPkg::operandsT chgOps [$];
    int                    numCycles;
    int                    cycleCount;
    int                    limit;

    // Model of which fetch address sits in decode and execute
    logic              dValid;
    logic              eValid;
    frontEndPkg::addrT dAddr;
    frontEndPkg::addrT eAddr;

    frontEndTop dut (
        .clk         (clk),
        .reset       (reset),
        .stallF_i    (stallF),
        .instrF_i    (instrF),
        .operandsE_i (operandsE),
        .pcF_o       (pcF),
        .mispredict_o(mispredict)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (limit > 0 && cycleCount > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    function automatic frontEndPkg::wordT fetchWord(input frontEndPkg::addrT addr);
        frontEndPkg::wordT word;
        word = NopWord;
        if (addr < MemWords * 4) begin
            word = progWord[addr[7:2]];
        end
        return word;
    endfunction

    // Later operand changes override the program values
    function automatic frontEndPkg::operandsT opsFor(input frontEndPkg::addrT addr,
                                                      input int cyc);
        frontEndPkg::operandsT ops;
        ops = '0;
        if (addr < MemWords * 4) begin
            ops = progOps[addr[7:2]];
        end
        for (int i = 0; i < chgCycle.size(); i++) begin
            if (chgAddr[i] == addr && chgCycle[i] <= cyc) begin
                ops = chgOps[i];
            end
        end
        return ops;
    endfunction

    task automatic readInput();
        int          fd;
        int          n;
        string       line;
        string       rest;
        logic [31:0] v [13];
        fd = $fopen("verification/frontEnd_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input data file");
            $display("TEST RESULT: FAIL");
            $fatal(1, "No input file");
        end
        while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
                rest = line.substr(1, line.len() - 1);
                case (line.getc(0))
                    "P": begin
                        n = $sscanf(rest, "%h %h %h %h", v[0], v[1], v[2], v[3]);
                        progWord[v[0][7:2]] = v[1];
                        progOps[v[0][7:2]]  = {v[2], v[3]};
                    end
                    "O": begin
                        n = $sscanf(rest, "%d %h %h %h", v[0], v[1], v[2], v[3]);
                        chgCycle.push_back(int'(v[0]));
                        chgAddr.push_back(v[1]);
                        chgOps.push_back({v[2], v[3]});
                    end
                    "S": begin
                        n = $sscanf(rest, "%d", v[0]);
                        stallAt[v[0]] = 1'b1;
                    end
                    "R": begin
                        n = $sscanf(rest, "%d", v[0]);
                        resetAt[v[0]] = 1'b1;
                    end
                    "E": begin
                        n = $sscanf(rest, "%d %h %d %h %d %h %d %h %d %h %d %h %d",
                                    v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                                    v[7], v[8], v[9], v[10], v[11], v[12]);
                        for (int k = 0; k < (n - 1) / 2; k++) begin
                            expPc[v[0] + k]  = v[1 + 2 * k];
                            expMis[v[0] + k] = v[2 + 2 * k][0];
                            if (v[0] + k + 1 > numCycles) begin
                                numCycles = v[0] + k + 1;
                            end
                        end
                    end
                    default: begin
                        $display("Unknown line in the input data file: %s", line);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "Bad input line");
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        stallF     = 1'b0;
        instrF     = NopWord;
        operandsE  = '0;
        cycleCount = 0;
        limit      = 0;
        numCycles  = 0;
        stallAt    = '0;
        resetAt    = '0;
        dValid     = 1'b0;
        eValid     = 1'b0;
        dAddr      = '0;
        eAddr      = '0;
        for (int i = 0; i < MemWords; i++) begin
            progWord[i] = NopWord;
            progOps[i]  = '0;
        end
        readInput();
        if (numCycles == 0) begin
            $display("The input data file holds no expected trace");
            $display("TEST RESULT: FAIL");
            $fatal(1, "Empty trace");
        end
        limit = numCycles + ResetCycles + 20;

        repeat (ResetCycles) @(posedge clk);
        #2;
        for (int c = 0; c < numCycles; c++) begin
            reset     = resetAt[c];
            stallF    = stallAt[c];
            instrF    = fetchWord(pcF);
            operandsE = eValid ? opsFor(eAddr, c) : '0;

            @(negedge clk);
            assert (pcF === expPc[c] && mispredict === expMis[c]) else begin
                $display("[ERROR] %0t ns: cycle %0d pcF_o=%h mispredict_o=%b, expected %h %b",
                         $time, c, pcF, mispredict, expPc[c], expMis[c]);
                $display("TEST RESULT: FAIL");
                $fatal(1, "Fetch trace mismatch");
            end

            // Advance the decode and execute model by one edge
            if (reset) begin
                dValid = 1'b0;
                eValid = 1'b0;
            end else begin
                eValid = dValid && !mispredict && !stallF;
                eAddr  = dAddr;
                if (mispredict) begin
                    dValid = 1'b0;
                end else if (!stallF) begin
                    dValid = 1'b1;
                    dAddr  = pcF;
                end
            end

            @(posedge clk);
            #2;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog/branchPredictor.sv
////////////////////////////////////////////////////////////
// Branch predictor: 32 entry BTB, gshare PHT of 2-bit
// counters and global history register
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "frontEnd_macros.svh"

module branchPredictor (
    input  logic                         clk,
    input  logic                         reset,
    input  frontEndPkg::addrT            pcF_i,
    input  frontEndPkg::wordT            instrF_i,
    input  logic                         stallF_i,
    input  frontEndPkg::predictorUpdateT update_i,
    output frontEndPkg::predictionT      prediction_o
);

    localparam int PhtEntries = 2 ** `FE_GHR_BITS;

    frontEndPkg::addrT    btbTarget [`FE_BTB_ENTRIES];
    logic [`FE_BTB_ENTRIES-1:0] btbValid;
    frontEndPkg::counterT pht [PhtEntries];
    frontEndPkg::historyT ghr;

    frontEndPkg::branchKindT kindF;
    frontEndPkg::btbIdxT     btbIdxF;
    frontEndPkg::historyT    phtIdxF;
    frontEndPkg::counterT    counterF;
    frontEndPkg::counterT    counterUpd;
    logic                    takenF;

    // Lookup for the instruction being fetched
    assign kindF    = frontEndPkg::decodeKind(instrF_i);
    assign btbIdxF  = pcF_i[`FE_BTB_IDX_BITS+1:2];
    assign phtIdxF  = ghr ^ pcF_i[`FE_BTB_IDX_BITS+1:2];
    assign counterF = pht[phtIdxF];

    always_comb begin
        takenF = 1'b0;
        if (btbValid[btbIdxF]) begin
            if (kindF == frontEndPkg::jump) begin
                takenF = 1'b1;
            end else if (kindF == frontEndPkg::condBranch) begin
                takenF = counterF[1];
            end
        end
    end

    always_comb begin
        prediction_o.taken  = takenF;
        prediction_o.target = btbTarget[btbIdxF];
        prediction_o.phtIdx = phtIdxF;
    end

    // Target storage, validity lives in btbValid
    always_ff @(posedge clk) begin
        if (update_i.btbWrite) begin
            btbTarget[update_i.btbIdx] <= update_i.btbTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            btbValid <= '0;
        end else if (update_i.btbWrite) begin
            btbValid[update_i.btbIdx] <= 1'b1;
        end
    end

    // Saturating count toward the resolved direction
    always_comb begin
        counterUpd = pht[update_i.phtIdx];
        if (update_i.phtTaken && counterUpd != 2'd3) begin
            counterUpd = counterUpd + 2'd1;
        end else if (!update_i.phtTaken && counterUpd != 2'd0) begin
            counterUpd = counterUpd - 2'd1;
        end
    end

    // Counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < PhtEntries; i++) begin
                pht[i] <= 2'd1;
            end
        end else if (update_i.phtWrite) begin
            pht[update_i.phtIdx] <= counterUpd;
        end
    end

    // History is speculative, so a misprediction wipes it
    always_ff @(posedge clk) begin
        if (reset || update_i.ghrClear) begin
            ghr <= '0;
        end else if (!stallF_i && kindF == frontEndPkg::condBranch) begin
            ghr <= {ghr[`FE_GHR_BITS-2:0], takenF};
        end
    end

endmodule

//--- verilog/branchResolver.sv
////////////////////////////////////////////////////////////
// Execute stage branch resolution: outcome, misprediction
// check, redirect and predictor update
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "frontEnd_macros.svh"

module branchResolver (
    input  logic                         clk,
    input  logic                         reset,
    input  frontEndPkg::decodeRegT       decode_i,
    input  logic                         stallF_i,
    input  frontEndPkg::operandsT        operandsE_i,
    output frontEndPkg::predictorUpdateT update_o,
    output logic                         redirectValid_o,
    output frontEndPkg::addrT            redirectPc_o
);

    frontEndPkg::decodeRegT  execReg;
    frontEndPkg::branchKindT kindE;
    frontEndPkg::wordT       instrE;
    frontEndPkg::addrT       immB;
    frontEndPkg::addrT       immJ;
    frontEndPkg::addrT       targetE;
    logic                    operandsEqual;
    logic                    actualTaken;
    logic                    predTaken;

    // Bubble on a stall (decode is held) or on our own redirect
    always_ff @(posedge clk) begin
        if (reset || redirectValid_o || stallF_i) begin
            execReg <= '0;
        end else begin
            execReg <= decode_i;
        end
    end

    assign instrE    = execReg.instr;
    assign kindE     = frontEndPkg::decodeKind(instrE);
    assign predTaken = execReg.prediction.taken;

    // B and J immediates, sign extended
    assign immB = {{(`FE_XLEN-12){instrE[31]}}, instrE[7], instrE[30:25],
                   instrE[11:8], 1'b0};
    assign immJ = {{(`FE_XLEN-20){instrE[31]}}, instrE[19:12], instrE[20],
                   instrE[30:21], 1'b0};

    always_comb begin
        if (kindE == frontEndPkg::jump) begin
            targetE = execReg.pc + immJ;
        end else begin
            targetE = execReg.pc + immB;
        end
    end

    assign operandsEqual = (operandsE_i.rs1Value == operandsE_i.rs2Value);

    always_comb begin
        case (kindE)
            frontEndPkg::jump: begin
                actualTaken = 1'b1;
            end
            frontEndPkg::condBranch: begin
                if (instrE[14:12] == `FE_F3_BNE) begin
                    actualTaken = !operandsEqual;
                end else begin
                    actualTaken = operandsEqual;
                end
            end
            default: begin
                actualTaken = 1'b0;
            end
        endcase
    end

    // Only the direction is checked, a bubble never mispredicts
    assign redirectValid_o = (kindE != frontEndPkg::none) && (predTaken != actualTaken);

    // Wrongly taken goes back to the fall through, wrongly not taken to the target
    assign redirectPc_o = predTaken ? execReg.pcPlus4 : targetE;

    always_comb begin
        update_o.btbWrite  = (kindE != frontEndPkg::none) && actualTaken;
        update_o.btbIdx    = execReg.pc[`FE_BTB_IDX_BITS+1:2];
        update_o.btbTarget = targetE;
        update_o.phtWrite  = (kindE == frontEndPkg::condBranch);
        update_o.phtIdx    = execReg.prediction.phtIdx;
        update_o.phtTaken  = actualTaken;
        update_o.ghrClear  = redirectValid_o;
    end

endmodule

//--- verilog/fetchStage.sv
////////////////////////////////////////////////////////////
// Fetch stage: PC register, next PC selection and the
// decode pipeline register
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "frontEnd_macros.svh"

module fetchStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   stallF_i,
    input  frontEndPkg::wordT      instrF_i,
    input  frontEndPkg::predictionT predictionF_i,
    input  logic                   redirectValid_i,
    input  frontEndPkg::addrT      redirectPc_i,
    output frontEndPkg::addrT      pcF_o,
    output frontEndPkg::decodeRegT decode_o
);

    frontEndPkg::addrT      pcPlus4F;
    frontEndPkg::addrT      pcNext;
    frontEndPkg::decodeRegT decodeNext;
    frontEndPkg::decodeRegT decodeReg;

    assign pcPlus4F = pcF_o + frontEndPkg::addrT'(4);

    // Redirect from execute beats the prediction, prediction beats pc+4
    always_comb begin
        if (redirectValid_i) begin
            pcNext = redirectPc_i;
        end else if (predictionF_i.taken) begin
            pcNext = predictionF_i.target;
        end else begin
            pcNext = pcPlus4F;
        end
    end

    // A redirect moves the PC even while fetch is stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF_o <= `FE_RESET_PC;
        end else if (redirectValid_i || !stallF_i) begin
            pcF_o <= pcNext;
        end
    end

    always_comb begin
        decodeNext.instr      = instrF_i;
        decodeNext.pc         = pcF_o;
        decodeNext.pcPlus4    = pcPlus4F;
        decodeNext.prediction = predictionF_i;
    end

    // All zero is a bubble: opcode 0 decodes to none, not taken
    always_ff @(posedge clk) begin
        if (reset || redirectValid_i) begin
            decodeReg <= '0;
        end else if (!stallF_i) begin
            decodeReg <= decodeNext;
        end
    end

    assign decode_o = decodeReg;

endmodule

//--- verilog/frontEndPkg.sv
////////////////////////////////////////////////////////////
// Shared types of the fetch front end
////////////////////////////////////////////////////////////
`include "frontEnd_macros.svh"

package frontEndPkg;

    typedef logic [`FE_XLEN-1:0]         addrT;
    typedef logic [`FE_XLEN-1:0]         wordT;
    typedef logic [`FE_BTB_IDX_BITS-1:0] btbIdxT;
    typedef logic [`FE_GHR_BITS-1:0]     historyT;
    typedef logic [1:0]                  counterT;

    typedef enum logic [1:0] {
        none,
        condBranch,
        jump
    } branchKindT;

    // Prediction made at fetch, carried down to execute
    typedef struct packed {
        logic    taken;
        addrT    target;
        historyT phtIdx;
    } predictionT;

    typedef struct packed {
        wordT       instr;
        addrT       pc;
        addrT       pcPlus4;
        predictionT prediction;
    } decodeRegT;

    typedef struct packed {
        wordT rs1Value;
        wordT rs2Value;
    } operandsT;

    // Table writes requested by execute
    typedef struct packed {
        logic    btbWrite;
        btbIdxT  btbIdx;
        addrT    btbTarget;
        logic    phtWrite;
        historyT phtIdx;
        logic    phtTaken;
        logic    ghrClear;
    } predictorUpdateT;

    // Only beq, bne and jal are recognized as control flow
    function automatic branchKindT decodeKind(input wordT instr);
        branchKindT kind;
        kind = none;
        if (instr[6:0] == `FE_OP_JAL) begin
            kind = jump;
        end else if (instr[6:0] == `FE_OP_BRANCH &&
                     (instr[14:12] == `FE_F3_BEQ || instr[14:12] == `FE_F3_BNE)) begin
            kind = condBranch;
        end
        return kind;
    endfunction

endpackage

//--- verilog/frontEndTop.sv
////////////////////////////////////////////////////////////
// Front end top: fetch, branch predictor and resolver
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module frontEndTop (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stallF_i,
    input  frontEndPkg::wordT     instrF_i,
    input  frontEndPkg::operandsT operandsE_i,
    output frontEndPkg::addrT     pcF_o,
    output logic                  mispredict_o
);

    frontEndPkg::addrT            pcF;
    frontEndPkg::predictionT      predictionF;
    frontEndPkg::decodeRegT       decodeD;
    frontEndPkg::predictorUpdateT updateE;
    logic                         redirectValid;
    frontEndPkg::addrT            redirectPc;

    fetchStage fetch (
        .clk            (clk),
        .reset          (reset),
        .stallF_i       (stallF_i),
        .instrF_i       (instrF_i),
        .predictionF_i  (predictionF),
        .redirectValid_i(redirectValid),
        .redirectPc_i   (redirectPc),
        .pcF_o          (pcF),
        .decode_o       (decodeD)
    );

    branchPredictor predictor (
        .clk         (clk),
        .reset       (reset),
        .pcF_i       (pcF),
        .instrF_i    (instrF_i),
        .stallF_i    (stallF_i),
        .update_i    (updateE),
        .prediction_o(predictionF)
    );

    branchResolver resolver (
        .clk            (clk),
        .reset          (reset),
        .decode_i       (decodeD),
        .stallF_i       (stallF_i),
        .operandsE_i    (operandsE_i),
        .update_o       (updateE),
        .redirectValid_o(redirectValid),
        .redirectPc_o   (redirectPc)
    );

    assign pcF_o        = pcF;
    assign mispredict_o = redirectValid;

endmodule

//--- verilog/frontEnd_macros.svh
////////////////////////////////////////////////////////////
// Front end constants: widths, predictor sizes, reset PC
// and the RISC-V opcode and funct3 values for beq, bne, jal
////////////////////////////////////////////////////////////
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// Address and data width
`define FE_XLEN          32

// Predictor sizes
`define FE_BTB_ENTRIES   32
`define FE_BTB_IDX_BITS  5
`define FE_GHR_BITS      5

// First fetch address after reset
`define FE_RESET_PC      32'h0000_0000

// Opcodes and funct3 codes
`define FE_OP_BRANCH     7'b1100011
`define FE_OP_JAL        7'b1101111
`define FE_F3_BEQ        3'b000
`define FE_F3_BNE        3'b001

`endif
